// File: hw/cpu_pkg.sv
package cpu_pkg;

  // Machine widths.
  localparam int ADDR_BITS = 32;
  localparam int DATA_BITS = 32;

  // Fetch restarts here after reset.
  localparam logic [ADDR_BITS-1:0] RESET_PC = 32'h0000_0000;

  // Trap vector until software writes its own.
  localparam logic [ADDR_BITS-1:0] MTVEC_RESET = 32'h0000_0100;

  // All zero decodes as an illegal word, so decode treats it as a bubble.
  localparam logic [DATA_BITS-1:0] INST_BUBBLE = 32'h0000_0000;

  // Source that steered the most recent PC update.
  typedef enum logic [1:0] {
    SEQ    = 2'd0,
    BRANCH = 2'd1,
    TRAP   = 2'd2,
    RET    = 2'd3
  } redirect_cause_e;

endpackage

// File: hw/isa_pkg.sv
package isa_pkg;

  // Major opcodes of the control-transfer instructions.
  localparam logic [6:0] OP_BRANCH = 7'b110_0011;
  localparam logic [6:0] OP_JAL    = 7'b110_1111;
  localparam logic [6:0] OP_JALR   = 7'b110_0111;

  // Branch condition codes.
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // One instruction word seen through the three formats that redirect fetch.
  // The opcode sits in the same bits in every view.
  typedef union packed {
    struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
    } btype;
    struct packed {
      logic [11:0] imm11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } itype;
    struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [4:0] imm19_15;
      logic [2:0] funct3;   // Immediate bits 14:12 in this format.
      logic [4:0] rd;
      logic [6:0] opcode;
    } jtype;
  } inst_u;

endpackage

// File: hw/if_id_if.sv
interface if_id_if import cpu_pkg::*; ();

  logic [ADDR_BITS-1:0] pc;
  logic [DATA_BITS-1:0] inst;
  logic                 valid;
  logic [ADDR_BITS-1:0] pc_plus4;

  // Fetch fills the register, decode reads it.
  modport producer (
    output pc,
    output inst,
    output valid,
    output pc_plus4
  );

  modport consumer (
    input pc,
    input inst,
    input valid,
    input pc_plus4
  );

endinterface

// File: hw/branch_resolver.sv
module branch_resolver import cpu_pkg::*; import isa_pkg::*; (
  input  logic                 exe_valid_i,
  input  inst_u                exe_inst_i,
  input  logic [ADDR_BITS-1:0] exe_pc_i,
  input  logic [DATA_BITS-1:0] rs1_i,
  input  logic [DATA_BITS-1:0] rs2_i,
  output logic                 br_taken_o,
  output logic [ADDR_BITS-1:0] br_target_o
);

  logic [ADDR_BITS-1:0] b_imm;
  logic [ADDR_BITS-1:0] i_imm;
  logic [ADDR_BITS-1:0] j_imm;
  logic [ADDR_BITS-1:0] jalr_sum;
  logic                 rs_eq;
  logic                 rs_lt;
  logic                 rs_ltu;
  logic                 cond;

  // Reassemble the scattered immediates, sign extended.
  assign b_imm = {{19{exe_inst_i.btype.imm12}}, exe_inst_i.btype.imm12,
                  exe_inst_i.btype.imm11, exe_inst_i.btype.imm10_5,
                  exe_inst_i.btype.imm4_1, 1'b0};
  assign i_imm = {{20{exe_inst_i.itype.imm11_0[11]}}, exe_inst_i.itype.imm11_0};
  assign j_imm = {{11{exe_inst_i.jtype.imm20}}, exe_inst_i.jtype.imm20,
                  exe_inst_i.jtype.imm19_15, exe_inst_i.jtype.funct3,
                  exe_inst_i.jtype.imm11, exe_inst_i.jtype.imm10_1, 1'b0};

  assign jalr_sum = rs1_i + i_imm;

  assign rs_eq  = (rs1_i == rs2_i);
  assign rs_lt  = ($signed(rs1_i) < $signed(rs2_i));
  assign rs_ltu = (rs1_i < rs2_i);

  always_comb begin
    case (exe_inst_i.btype.funct3)
      F3_BEQ:  cond = rs_eq;
      F3_BNE:  cond = !rs_eq;
      F3_BLT:  cond = rs_lt;
      F3_BGE:  cond = !rs_lt;
      F3_BLTU: cond = rs_ltu;
      F3_BGEU: cond = !rs_ltu;
      default: cond = 1'b0;   // Reserved codes never branch.
    endcase
  end

  always_comb begin
    br_taken_o  = 1'b0;
    br_target_o = exe_pc_i + b_imm;
    if (exe_valid_i) begin
      case (exe_inst_i.btype.opcode)
        OP_BRANCH: begin
          br_taken_o  = cond;
          br_target_o = exe_pc_i + b_imm;
        end
        OP_JAL: begin
          br_taken_o  = 1'b1;
          br_target_o = exe_pc_i + j_imm;
        end
        OP_JALR: begin
          br_taken_o  = 1'b1;
          br_target_o = {jalr_sum[ADDR_BITS-1:1], 1'b0};
        end
        default: br_taken_o = 1'b0;
      endcase
    end
  end

  // A taken redirect must land on a halfword boundary.
  always_comb begin
    if (br_taken_o) begin
      a_target_align: assert #0 (!br_target_o[0])
        else $error("Taken branch target is not halfword aligned.");
    end
  end

endmodule

// File: hw/trap_unit.sv
module trap_unit import cpu_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 irq_i,
  input  logic                 mret_i,
  input  logic                 mtvec_wr_i,
  input  logic [ADDR_BITS-1:0] mtvec_data_i,
  input  logic [ADDR_BITS-1:0] fetch_pc_i,
  output logic                 trap_redirect_o,
  output logic [ADDR_BITS-1:0] trap_target_o,
  output logic                 trap_ret_o,
  output logic [ADDR_BITS-1:0] mepc_o,
  output logic                 mie_o
);

  logic [ADDR_BITS-1:0] mtvec_q;
  logic [ADDR_BITS-1:0] mepc_q;
  logic                 mie_q;
  logic                 irq_take;

  // A return in the same cycle shadows the interrupt.
  assign irq_take = irq_i && mie_q && !mret_i;

  assign trap_redirect_o = mret_i || irq_take;
  assign trap_ret_o      = mret_i;
  assign trap_target_o   = mret_i ? mepc_q : mtvec_q;

  assign mepc_o = mepc_q;
  assign mie_o  = mie_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      mtvec_q <= MTVEC_RESET;
      mepc_q  <= RESET_PC;
      mie_q   <= 1'b1;
    end else begin
      if (mtvec_wr_i) begin
        mtvec_q <= {mtvec_data_i[ADDR_BITS-1:1], 1'b0};
      end
      if (mret_i) begin
        mie_q <= 1'b1;
      end else if (irq_take) begin
        mepc_q <= fetch_pc_i;   // Resume at the instruction that was not fetched.
        mie_q  <= 1'b0;
      end
    end
  end

  // Entry clears the enable, so on the next edge only a return may redirect.
  a_no_spurious_redirect: assert property (
    @(posedge clk) disable iff (rst)
    (trap_redirect_o && !mret_i) |=> (!trap_redirect_o || mret_i)
  ) else $error("Interrupt entry repeated without a return in between.");

endmodule

// File: hw/fetch_stage.sv
module fetch_stage import cpu_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 stall_i,
  input  logic [DATA_BITS-1:0] inst_i,
  input  logic                 br_taken_i,
  input  logic [ADDR_BITS-1:0] br_target_i,
  input  logic                 trap_redirect_i,
  input  logic                 trap_ret_i,
  input  logic [ADDR_BITS-1:0] trap_target_i,
  output logic [ADDR_BITS-1:0] pc_o,
  output redirect_cause_e      cause_o,
  if_id_if.producer            if_id
);

  logic [ADDR_BITS-1:0] pc_q;
  logic [ADDR_BITS-1:0] pc_d;
  logic [ADDR_BITS-1:0] pc_plus4;
  redirect_cause_e      cause_q;
  redirect_cause_e      cause_d;
  logic                 redirect;

  assign pc_plus4 = pc_q + 32'd4;
  assign redirect = trap_redirect_i || br_taken_i;

  // Trap unit already orders return over interrupt entry.
  always_comb begin
    pc_d    = pc_plus4;
    cause_d = SEQ;
    if (trap_redirect_i) begin
      pc_d    = trap_target_i;
      cause_d = trap_ret_i ? RET : TRAP;
    end else if (br_taken_i) begin
      pc_d    = br_target_i;
      cause_d = BRANCH;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc_q    <= RESET_PC;
      cause_q <= SEQ;
    end else if (redirect || !stall_i) begin   // A redirect overrides the stall.
      pc_q    <= pc_d;
      cause_q <= cause_d;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      if_id.pc       <= RESET_PC;
      if_id.inst     <= INST_BUBBLE;
      if_id.valid    <= 1'b0;
      if_id.pc_plus4 <= RESET_PC;
    end else if (redirect) begin
      if_id.pc       <= pc_q;
      if_id.inst     <= INST_BUBBLE;
      if_id.valid    <= 1'b0;
      if_id.pc_plus4 <= pc_plus4;
    end else if (!stall_i) begin
      if_id.pc       <= pc_q;
      if_id.inst     <= inst_i;
      if_id.valid    <= 1'b1;
      if_id.pc_plus4 <= pc_plus4;
    end
  end

  assign pc_o    = pc_q;
  assign cause_o = cause_q;

  a_flush_clears_valid: assert property (
    @(posedge clk) disable iff (rst)
    redirect |=> !if_id.valid
  ) else $error("IF/ID still valid after a redirect.");

  a_stall_holds_pc: assert property (
    @(posedge clk) disable iff (rst)
    (stall_i && !redirect) |=> $stable(pc_o)
  ) else $error("PC moved during a stall without redirect.");

endmodule

// File: hw/fetch_top.sv
module fetch_top import cpu_pkg::*; import isa_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 stall_i,
  input  logic [DATA_BITS-1:0] inst_i,
  input  logic                 exe_valid_i,
  input  logic [DATA_BITS-1:0] exe_inst_i,
  input  logic [ADDR_BITS-1:0] exe_pc_i,
  input  logic [DATA_BITS-1:0] rs1_i,
  input  logic [DATA_BITS-1:0] rs2_i,
  input  logic                 irq_i,
  input  logic                 mret_i,
  input  logic                 mtvec_wr_i,
  input  logic [ADDR_BITS-1:0] mtvec_data_i,
  output logic [ADDR_BITS-1:0] inst_pc_o,
  output logic [ADDR_BITS-1:0] id_pc_o,
  output logic [DATA_BITS-1:0] id_inst_o,
  output logic [ADDR_BITS-1:0] id_pc_plus4_o,
  output logic                 id_valid_o,
  output redirect_cause_e      cause_o,
  output logic [ADDR_BITS-1:0] mepc_o,
  output logic                 mie_o
);

  logic                 br_taken;
  logic [ADDR_BITS-1:0] br_target;
  logic                 trap_redirect;
  logic                 trap_ret;
  logic [ADDR_BITS-1:0] trap_target;

  if_id_if if_id_bus ();

  branch_resolver u_branch (
    .exe_valid_i (exe_valid_i),
    .exe_inst_i  (inst_u'(exe_inst_i)),
    .exe_pc_i    (exe_pc_i),
    .rs1_i       (rs1_i),
    .rs2_i       (rs2_i),
    .br_taken_o  (br_taken),
    .br_target_o (br_target)
  );

  trap_unit u_trap (
    .clk             (clk),
    .rst             (rst),
    .irq_i           (irq_i),
    .mret_i          (mret_i),
    .mtvec_wr_i      (mtvec_wr_i),
    .mtvec_data_i    (mtvec_data_i),
    .fetch_pc_i      (inst_pc_o),
    .trap_redirect_o (trap_redirect),
    .trap_target_o   (trap_target),
    .trap_ret_o      (trap_ret),
    .mepc_o          (mepc_o),
    .mie_o           (mie_o)
  );

  fetch_stage u_fetch (
    .clk             (clk),
    .rst             (rst),
    .stall_i         (stall_i),
    .inst_i          (inst_i),
    .br_taken_i      (br_taken),
    .br_target_i     (br_target),
    .trap_redirect_i (trap_redirect),
    .trap_ret_i      (trap_ret),
    .trap_target_i   (trap_target),
    .pc_o            (inst_pc_o),
    .cause_o         (cause_o),
    .if_id           (if_id_bus.producer)
  );

  // Decode side of the IF/ID register.
  assign id_pc_o       = if_id_bus.pc;
  assign id_inst_o     = if_id_bus.inst;
  assign id_pc_plus4_o = if_id_bus.pc_plus4;
  assign id_valid_o    = if_id_bus.valid;

endmodule

// File: sim/fetch_tb.sv
module fetch_tb import cpu_pkg::*; import isa_pkg::*; ();

  localparam int PERIOD       = 100;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_TESTS    = 6;
  localparam int TOTAL_CYCLES = 220;   // Sum of the test lengths below.
  localparam int MARGIN       = 50;

  typedef struct packed {
    logic [ADDR_BITS-1:0] pc;
    logic [ADDR_BITS-1:0] id_pc;
    logic [DATA_BITS-1:0] id_inst;
    logic [ADDR_BITS-1:0] id_pc_plus4;
    logic                 id_valid;
    redirect_cause_e      cause;
    logic [ADDR_BITS-1:0] mepc;
    logic                 mie;
    logic [ADDR_BITS-1:0] mtvec;
  } model_t;

  logic clk;
  logic rst;
  logic stall, exe_valid, irq, mret, mtvec_wr;
  logic [DATA_BITS-1:0] fetch_inst, exe_inst, rs1, rs2;
  logic [ADDR_BITS-1:0] exe_pc, mtvec_data;
  logic [ADDR_BITS-1:0] inst_pc, id_pc, id_pc_plus4, mepc;
  logic [DATA_BITS-1:0] id_inst;
  logic                 id_valid, mie;
  redirect_cause_e      cause;

  model_t      m;
  logic [31:0] seed = 32'h2449;
  string       cur_test = "reset";
  string       chk_test = "reset";
  int          test_len [NUM_TESTS] = '{20, 60, 30, 30, 40, 40};
  string       test_name [NUM_TESTS] = '{"sequential", "branch", "jump", "stall", "trap",
                                         "priority"};

  fetch_top uut (
    .clk (clk), .rst (rst), .stall_i (stall), .inst_i (fetch_inst),
    .exe_valid_i (exe_valid), .exe_inst_i (exe_inst), .exe_pc_i (exe_pc),
    .rs1_i (rs1), .rs2_i (rs2), .irq_i (irq), .mret_i (mret),
    .mtvec_wr_i (mtvec_wr), .mtvec_data_i (mtvec_data),
    .inst_pc_o (inst_pc), .id_pc_o (id_pc), .id_inst_o (id_inst),
    .id_pc_plus4_o (id_pc_plus4), .id_valid_o (id_valid), .cause_o (cause),
    .mepc_o (mepc), .mie_o (mie)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] next_rand();
    seed = xorshift(seed);
    return seed;
  endfunction

  // Returns {taken, target} for the instruction in the execute slot.
  function automatic logic [32:0] branch_outcome(input logic v, input logic [31:0] w,
                                                 input logic [31:0] pc, input logic [31:0] a,
                                                 input logic [31:0] b);
    logic [31:0] b_imm, i_imm, j_imm, sum;
    logic        cond;
    b_imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    i_imm = {{20{w[31]}}, w[31:20]};
    j_imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    case (w[14:12])
      F3_BEQ:  cond = (a == b);
      F3_BNE:  cond = (a != b);
      F3_BLT:  cond = ($signed(a) < $signed(b));
      F3_BGE:  cond = ($signed(a) >= $signed(b));
      F3_BLTU: cond = (a < b);
      F3_BGEU: cond = (a >= b);
      default: cond = 1'b0;
    endcase
    sum = a + i_imm;
    if (!v) return {1'b0, 32'h0};
    if (w[6:0] == OP_BRANCH) return {cond, pc + b_imm};
    if (w[6:0] == OP_JAL) return {1'b1, pc + j_imm};
    if (w[6:0] == OP_JALR) return {1'b1, sum[31:1], 1'b0};
    return {1'b0, 32'h0};
  endfunction

  function automatic model_t ref_next(input model_t s, input logic st, input logic [31:0] fi,
                                      input logic ev, input logic [31:0] ei,
                                      input logic [31:0] ep, input logic [31:0] a,
                                      input logic [31:0] b, input logic iq, input logic mr,
                                      input logic mw, input logic [31:0] md);
    model_t      n;
    logic [32:0] br;
    logic        redirect;
    n = s;
    br = branch_outcome(ev, ei, ep, a, b);
    redirect = 1'b1;
    if (mr) begin   // Return outranks everything else.
      n.pc = s.mepc;
      n.cause = RET;
      n.mie = 1'b1;
    end else if (iq && s.mie) begin
      n.pc = s.mtvec;
      n.cause = TRAP;
      n.mepc = s.pc;
      n.mie = 1'b0;
    end else if (br[32]) begin
      n.pc = br[31:0];
      n.cause = BRANCH;
    end else begin
      redirect = 1'b0;
      if (!st) begin
        n.pc = s.pc + 32'd4;
        n.cause = SEQ;
      end
    end
    if (mw) n.mtvec = {md[31:1], 1'b0};
    if (redirect) begin
      n.id_pc = s.pc;
      n.id_inst = INST_BUBBLE;
      n.id_valid = 1'b0;
      n.id_pc_plus4 = s.pc + 32'd4;
    end else if (!st) begin
      n.id_pc = s.pc;
      n.id_inst = fi;
      n.id_valid = 1'b1;
      n.id_pc_plus4 = s.pc + 32'd4;
    end
    return n;
  endfunction

  task automatic step_model();
    chk_test = cur_test;
    m = ref_next(m, stall, fetch_inst, exe_valid, exe_inst, exe_pc, rs1, rs2, irq, mret,
                 mtvec_wr, mtvec_data);
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
      $display("Checks failed");
      $fatal(1, "Stopped at the first mismatch.");
    end
  endtask

  task automatic check_cause(input string name, input redirect_cause_e exp,
                             input redirect_cause_e act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected %s, actual %s", name, exp.name(), act.name());
      $display("Checks failed");
      $fatal(1, "Stopped at the first mismatch.");
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
      $display("Checks failed");
      $fatal(1, "Stopped at the first mismatch.");
    end
  endtask

  // Random instruction word with its opcode and, for branches, its condition forced.
  task automatic drive_inputs(input int t, input int k);
    logic [31:0] r, w, a, p;
    logic [2:0]  f3;
    r = next_rand();
    w = next_rand();
    a = next_rand();
    fetch_inst <= next_rand();
    p = next_rand();
    exe_pc <= {p[31:2], 2'b00};
    rs1 <= a;
    rs2 <= next_rand();
    mtvec_data <= next_rand();
    stall <= 1'b0;
    exe_valid <= 1'b0;
    irq <= 1'b0;
    mret <= 1'b0;
    mtvec_wr <= 1'b0;
    exe_inst <= {w[31:7], OP_JAL};
    case (t)
      1: begin
        exe_valid <= 1'b1;
        case (k % 6)
          0:       f3 = F3_BEQ;
          1:       f3 = F3_BNE;
          2:       f3 = F3_BLT;
          3:       f3 = F3_BGE;
          4:       f3 = F3_BLTU;
          default: f3 = F3_BGEU;
        endcase
        exe_inst <= {w[31:15], f3, w[11:7], OP_BRANCH};
        if (r[1:0] == 2'd0) rs2 <= a;   // Equal operands.
        else if (r[1:0] == 2'd1) rs2 <= {~a[31], r[30:0]};   // Opposite signs.
      end
      2: begin
        exe_valid <= (r[2:0] != 3'd0);   // Some slots are invalid.
        exe_inst <= {w[31:7], r[3] ? OP_JALR : OP_JAL};
      end
      3: begin
        stall <= r[0];
        exe_valid <= (r[3:2] == 2'd0);
      end
      4: begin
        mtvec_wr <= (k == 0) || (k >= 8 && r[7:5] == 3'd0);
        irq <= (k >= 2 && k <= 4) || (k >= 8 && r[0] && r[1]);
        mret <= (k == 6) || (k >= 8 && r[4:2] == 3'd0);
      end
      5: begin
        mret <= r[0] || (k % 8 == 0);
        irq <= r[1] || (k % 8 <= 1);
        exe_valid <= r[2] || (k % 8 <= 1);
        stall <= r[3];
      end
      default: ;
    endcase
  endtask

  initial begin
    stall = 1'b0;
    fetch_inst = '0;
    exe_valid = 1'b0;
    exe_inst = '0;
    exe_pc = '0;
    rs1 = '0;
    rs2 = '0;
    irq = 1'b0;
    mret = 1'b0;
    mtvec_wr = 1'b0;
    mtvec_data = '0;
    m = '{RESET_PC, RESET_PC, INST_BUBBLE, RESET_PC, 1'b0, SEQ, RESET_PC, 1'b1, MTVEC_RESET};
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      for (int k = 0; k < test_len[t]; k++) begin
        @(posedge clk);
        step_model();
        cur_test = test_name[t];
        drive_inputs(t, k);
      end
    end
    @(posedge clk);
    step_model();
    @(negedge clk);
    #10;
    $display("All checks passed");
    $finish;
  end

  // Outputs are stable at the falling edge.
  initial begin
    @(negedge rst);
    forever begin
      @(negedge clk);
      check_word({chk_test, " pc"}, m.pc, inst_pc);
      check_word({chk_test, " id_pc"}, m.id_pc, id_pc);
      check_word({chk_test, " id_inst"}, m.id_inst, id_inst);
      check_word({chk_test, " id_pc_plus4"}, m.id_pc_plus4, id_pc_plus4);
      check_flag({chk_test, " id_valid"}, m.id_valid, id_valid);
      check_cause({chk_test, " cause"}, m.cause, cause);
      check_word({chk_test, " mepc"}, m.mepc, mepc);
      check_flag({chk_test, " mie"}, m.mie, mie);
    end
  end

  initial begin
    #((RESET_CYCLES + TOTAL_CYCLES + 1 + MARGIN) * PERIOD);
    $display("The run timed out before all tests finished.");
    $display("Checks failed");
    $fatal(1, "Watchdog expired.");
  end

endmodule

// File: src.f
hw/cpu_pkg.sv
hw/isa_pkg.sv
hw/if_id_if.sv
hw/branch_resolver.sv
hw/trap_unit.sv
hw/fetch_stage.sv
hw/fetch_top.sv
sim/fetch_tb.sv

// File: Bender.yml
package:
  name: fetch_frontend

sources:
  - hw/cpu_pkg.sv
  - hw/isa_pkg.sv
  - hw/if_id_if.sv
  - hw/branch_resolver.sv
  - hw/trap_unit.sv
  - hw/fetch_stage.sv
  - hw/fetch_top.sv
  - target: simulation
    files:
      - sim/fetch_tb.sv
